// ==== common/mdec_macros.svh ====
// Width and constant macros for the MDEC front end, included by the RTL, the package and the testbench
`ifndef MDEC_MACROS_SVH
`define MDEC_MACROS_SVH

// --------------------
// Datapath widths
// --------------------
// Signed RLE level
`define MDEC_COEF_W   10
// Per-block quantization scale
`define MDEC_SCALE_W  6
// One quantization table entry
`define MDEC_QENT_W   7
// Dequantized coefficient, product bits 22..3
`define MDEC_OUT_W    20

// --------------------
// Stream constants
// --------------------
// End-of-block halfword
`define MDEC_END_CODE 16'hFE00
// Blocks per macroblock, 2 chroma then 4 luma
`define MDEC_BLOCKS   6

`endif

// ==== common/mdecPkg.sv ====
// Shared types and the zigzag index map for the MDEC front end, referenced by scoped name
`include "mdec_macros.svh"

package mdecPkg;

	// Four table entries, entry 0 sits in the low bits
	typedef struct packed
	{
		logic [`MDEC_QENT_W-1:0] e3;
		logic [`MDEC_QENT_W-1:0] e2;
		logic [`MDEC_QENT_W-1:0] e1;
		logic [`MDEC_QENT_W-1:0] e0;
	} quantEntries_t;

	// One table word, raw as loaded or split into entries
	typedef union packed
	{
		logic [4*`MDEC_QENT_W-1:0] raw;
		quantEntries_t             ent;
	} quantWord_t;

	// Zigzag position to row-major index
	localparam logic [5:0] zagTable [64] = '{
		6'd0,  6'd1,  6'd8,  6'd16, 6'd9,  6'd2,  6'd3,  6'd10,
		6'd17, 6'd24, 6'd32, 6'd25, 6'd18, 6'd11, 6'd4,  6'd5,
		6'd12, 6'd19, 6'd26, 6'd33, 6'd40, 6'd48, 6'd41, 6'd34,
		6'd27, 6'd20, 6'd13, 6'd6,  6'd7,  6'd14, 6'd21, 6'd28,
		6'd35, 6'd42, 6'd49, 6'd56, 6'd57, 6'd50, 6'd43, 6'd36,
		6'd29, 6'd22, 6'd15, 6'd23, 6'd30, 6'd37, 6'd44, 6'd51,
		6'd58, 6'd59, 6'd52, 6'd45, 6'd38, 6'd31, 6'd39, 6'd46,
		6'd53, 6'd60, 6'd61, 6'd54, 6'd47, 6'd55, 6'd62, 6'd63
	};

	// Plain lookup, synthesizes to a small ROM
	function automatic logic [5:0] zagToLinear(input logic [5:0] zag);
		return zagTable[zag];
	endfunction

endpackage

// ==== logic/rleDecode.sv ====
// Expands run-length halfwords into tagged coefficients for the dequantizer inside mdecCore
`timescale 1ns/1ps
`include "mdec_macros.svh"

module rleDecode (
	input  logic                           i_clk,
	input  logic                           i_arstN,

	// Halfword stream
	input  logic                           i_rleValid,
	input  logic [15:0]                    i_rleData,
	input  logic                           i_fullBlockType,

	// Coefficient stream, one cycle after the halfword
	output logic                           o_dataWrt,
	output logic signed [`MDEC_COEF_W-1:0] o_dataIn,
	output logic [`MDEC_SCALE_W-1:0]       o_scale,
	output logic                           o_isDC,
	output logic [5:0]                     o_index,
	output logic [5:0]                     o_zagIndex,
	output logic                           o_fullBlockType,
	output logic [2:0]                     o_blockNum,
	output logic                           o_matrixComplete
);

	// --------------------
	// Halfword fields
	// --------------------
	// Run, or the block scale on a DC halfword
	logic [`MDEC_SCALE_W-1:0]       hwUpper;
	logic signed [`MDEC_COEF_W-1:0] hwLevel;
	logic                           isEnd;

	// Block state
	logic                           firstHw;
	logic [5:0]                     zagPos;
	logic                           pastEnd;
	logic [`MDEC_SCALE_W-1:0]       heldScale;
	logic [2:0]                     blockCnt;

	// Next position, bit 6 flags a run past 63
	logic [6:0]                     nextPos;
	logic                           dropCoef;
	logic [5:0]                     wrZag;

	assign hwUpper = i_rleData[15 -: `MDEC_SCALE_W];
	assign hwLevel = i_rleData[`MDEC_COEF_W-1:0];

	// End code only counts after the DC halfword
	assign isEnd = !firstHw && (i_rleData == `MDEC_END_CODE);

	assign nextPos  = {1'b0, zagPos} + {1'b0, hwUpper} + 7'd1;
	assign dropCoef = pastEnd || nextPos[6];
	assign wrZag    = firstHw ? 6'd0 : nextPos[5:0];

	// --------------------
	// Control
	// --------------------
	always_ff @(posedge i_clk or negedge i_arstN)
	begin
		if (!i_arstN)
		begin
			firstHw          <= 1'b1;
			zagPos           <= '0;
			pastEnd          <= 1'b0;
			blockCnt         <= '0;
			o_dataWrt        <= 1'b0;
			o_matrixComplete <= 1'b0;
		end
		else
		begin
			// Single-cycle strobes
			o_dataWrt        <= 1'b0;
			o_matrixComplete <= 1'b0;
			if (i_rleValid)
			begin
				if (firstHw)
				begin
					// DC lands at zigzag 0
					firstHw   <= 1'b0;
					zagPos    <= '0;
					pastEnd   <= 1'b0;
					o_dataWrt <= 1'b1;
				end
				else if (isEnd)
				begin
					firstHw          <= 1'b1;
					o_matrixComplete <= 1'b1;
					// Block number wraps after the last luma block
					if (blockCnt == 3'(`MDEC_BLOCKS - 1))
						blockCnt <= '0;
					else
						blockCnt <= blockCnt + 3'd1;
				end
				else if (dropCoef)
				begin
					// Swallow everything up to the end code
					pastEnd <= 1'b1;
				end
				else
				begin
					zagPos    <= nextPos[5:0];
					o_dataWrt <= 1'b1;
				end
			end
		end
	end

	// --------------------
	// Payload
	// --------------------
	always_ff @(posedge i_clk)
	begin
		if (i_rleValid)
		begin
			o_dataIn        <= hwLevel;
			// Scale comes straight from the DC halfword
			o_scale         <= firstHw ? hwUpper : heldScale;
			o_isDC          <= firstHw;
			o_zagIndex      <= wrZag;
			o_index         <= mdecPkg::zagToLinear(wrZag);
			o_fullBlockType <= i_fullBlockType;
			// End pulse still carries the finishing block
			o_blockNum      <= blockCnt;
			if (firstHw)
				heldScale <= hwUpper;
		end
	end

endmodule

// ==== computeCoef/computeCoef.sv ====
// Two-stage dequantizer with its own quantization table, between rleDecode and blockStore
`timescale 1ns/1ps
`include "mdec_macros.svh"

// Standard mode
//   DC     coef x 8 x quant[0] / 8
//   others coef x scale x quant[zag] / 8
// Full matrix mode
//   all    coef x 16 x 1 / 8
module computeCoef (
	input  logic                           i_clk,
	input  logic                           i_arstN,

	// Coefficient stream from the decoder
	input  logic                           i_dataWrt,
	input  logic signed [`MDEC_COEF_W-1:0] i_dataIn,
	input  logic [`MDEC_SCALE_W-1:0]       i_scale,
	input  logic                           i_isDC,
	input  logic [5:0]                     i_index,
	// Table is stored in zigzag order
	input  logic [5:0]                     i_zagIndex,
	input  logic                           i_fullBlockType,
	input  logic [2:0]                     i_blockNum,
	input  logic                           i_matrixComplete,

	// Table load
	input  logic                           i_quantWrt,
	input  mdecPkg::quantWord_t            i_quantValue,
	input  logic [3:0]                     i_quantAdr,
	input  logic                           i_quantTblSelect,

	// Store side, two cycles after i_dataWrt
	output logic                           o_write,
	output logic [5:0]                     o_writeIdx,
	output logic [2:0]                     o_blockNum,
	output logic signed [`MDEC_OUT_W-1:0]  o_coefValue,
	output logic                           o_matrixComplete
);

	// 10x7 signed then 16x8 signed
	localparam int prodW0 = `MDEC_COEF_W + `MDEC_SCALE_W;
	localparam int prodW1 = prodW0 + `MDEC_QENT_W + 1;

	// --------------------
	// Stage 0
	// --------------------
	logic [`MDEC_SCALE_W-1:0]       effScale;
	logic signed [`MDEC_SCALE_W:0]  signedScale;
	logic signed [prodW0-1:0]       multF;
	logic                           tblSel;

	// Quant table, 2 x 16 words
	logic [4*`MDEC_QENT_W-1:0]      quantTbl [32];

	logic                           pWrite;
	logic                           pMatrixComplete;
	logic [5:0]                     pIndex;
	logic [2:0]                     pBlk;
	logic                           pFullBlkType;
	logic signed [prodW0-1:0]       pMultF;
	logic [1:0]                     pEntSel;
	mdecPkg::quantWord_t            pQuantWord;

	// 16 in full mode wins over the DC factor
	assign effScale = i_fullBlockType ? `MDEC_SCALE_W'(16)
		: (i_isDC ? `MDEC_SCALE_W'(8) : i_scale);
	assign signedScale = {1'b0, effScale};
	assign multF       = prodW0'(i_dataIn) * prodW0'(signedScale);

	// Blocks 0-1 chroma table, 2-5 luma table
	assign tblSel = (i_blockNum > 3'd1);

	always_ff @(posedge i_clk or negedge i_arstN)
	begin
		if (!i_arstN)
		begin
			pWrite          <= 1'b0;
			pMatrixComplete <= 1'b0;
		end
		else
		begin
			pWrite          <= i_dataWrt;
			pMatrixComplete <= i_matrixComplete;
		end
	end

	always_ff @(posedge i_clk)
	begin
		pIndex       <= i_index;
		pBlk         <= i_blockNum;
		pFullBlkType <= i_fullBlockType;
		pMultF       <= multF;
		// Word read lines up with the first product
		pQuantWord.raw <= quantTbl[{tblSel, i_zagIndex[5:2]}];
		pEntSel        <= i_zagIndex[1:0];
		// Loader writes only between blocks
		if (i_quantWrt)
			quantTbl[{i_quantTblSelect, i_quantAdr}] <= i_quantValue.raw;
	end

	// --------------------
	// Stage 1
	// --------------------
	logic [`MDEC_QENT_W-1:0]        quantEntry;
	logic signed [`MDEC_QENT_W:0]   quant;
	logic signed [prodW1-1:0]       outCalc;

	logic                           ppWrite;
	logic                           ppMatrixComplete;
	logic [5:0]                     ppIndex;
	logic [2:0]                     ppBlk;
	logic signed [`MDEC_OUT_W-1:0]  ppCoef;

	// Entry pick from the word view
	always_comb
	begin
		case (pEntSel)
			2'd0:    quantEntry = pQuantWord.ent.e0;
			2'd1:    quantEntry = pQuantWord.ent.e1;
			2'd2:    quantEntry = pQuantWord.ent.e2;
			default: quantEntry = pQuantWord.ent.e3;
		endcase
	end

	// Unity factor in full mode
	assign quant   = pFullBlkType ? (`MDEC_QENT_W + 1)'(1) : {1'b0, quantEntry};
	assign outCalc = prodW1'(pMultF) * prodW1'(quant);

	always_ff @(posedge i_clk or negedge i_arstN)
	begin
		if (!i_arstN)
		begin
			ppWrite          <= 1'b0;
			ppMatrixComplete <= 1'b0;
		end
		else
		begin
			ppWrite          <= pWrite;
			ppMatrixComplete <= pMatrixComplete;
		end
	end

	always_ff @(posedge i_clk)
	begin
		ppIndex <= pIndex;
		ppBlk   <= pBlk;
		// Divide by 8, keep 20 bits
		ppCoef  <= outCalc[`MDEC_OUT_W+2:3];
	end

	assign o_write          = ppWrite;
	assign o_writeIdx       = ppIndex;
	assign o_blockNum       = ppBlk;
	assign o_coefValue      = ppCoef;
	assign o_matrixComplete = ppMatrixComplete;

endmodule

// ==== logic/blockStore.sv ====
// Ping-pong coefficient store that fills blocks and streams them out in linear order
`timescale 1ns/1ps
`include "mdec_macros.svh"

module blockStore (
	input  logic                          i_clk,
	input  logic                          i_arstN,

	// Write side from the dequantizer
	input  logic                          i_write,
	input  logic [5:0]                    i_writeIdx,
	input  logic [2:0]                    i_blockNum,
	input  logic signed [`MDEC_OUT_W-1:0] i_coefValue,
	input  logic                          i_matrixComplete,

	// Readout, 64 beats per block
	output logic                          o_outValid,
	output logic [5:0]                    o_outIdx,
	output logic [2:0]                    o_outBlock,
	output logic signed [`MDEC_OUT_W-1:0] o_outValue,
	output logic                          o_inReady
);

	// --------------------
	// Bank state
	// --------------------
	// Both banks in one array, bank select on top
	logic signed [`MDEC_OUT_W-1:0] mem [128];
	// Written positions per bank
	logic [63:0]                   mask [2];
	logic [2:0]                    bankBlk [2];
	logic [1:0]                    full;
	logic                          fillSel;
	logic                          rdSel;
	logic [5:0]                    rdCnt;

	// Block in flight upstream may still claim the second bank,
	// so a new block starts only with both banks free
	assign o_inReady = !full[0] && !full[1] && !i_matrixComplete;

	always_ff @(posedge i_clk or negedge i_arstN)
	begin
		if (!i_arstN)
		begin
			mask[0]    <= '0;
			mask[1]    <= '0;
			full       <= '0;
			fillSel    <= 1'b0;
			rdSel      <= 1'b0;
			rdCnt      <= '0;
			o_outValid <= 1'b0;
		end
		else
		begin
			if (i_write)
				mask[fillSel][i_writeIdx] <= 1'b1;

			// Completion closes the fill bank
			if (i_matrixComplete)
			begin
				full[fillSel] <= 1'b1;
				fillSel       <= !fillSel;
			end

			// Banks are read in completion order
			o_outValid <= full[rdSel];
			if (full[rdSel])
			begin
				rdCnt <= rdCnt + 6'd1;
				if (rdCnt == 6'd63)
				begin
					// Last beat frees the bank
					full[rdSel] <= 1'b0;
					mask[rdSel] <= '0;
					rdSel       <= !rdSel;
				end
			end
		end
	end

	// --------------------
	// Data path
	// --------------------
	always_ff @(posedge i_clk)
	begin
		if (i_write)
			mem[{fillSel, i_writeIdx}] <= i_coefValue;
		if (i_matrixComplete)
			bankBlk[fillSel] <= i_blockNum;

		o_outIdx   <= rdCnt;
		o_outBlock <= bankBlk[rdSel];
		// Skipped positions read as zero
		o_outValue <= mask[rdSel][rdCnt] ? mem[{rdSel, rdCnt}] : '0;
	end

endmodule

// ==== logic/mdecCore.sv ====
// Top of the MDEC front end, chaining the RLE decoder, dequantizer and block store
`timescale 1ns/1ps
`include "mdec_macros.svh"

module mdecCore (
	input  logic                          i_clk,
	input  logic                          i_arstN,

	// Halfword stream and mode
	input  logic                          i_rleValid,
	input  logic [15:0]                   i_rleData,
	input  logic                          i_fullBlockType,

	// Quant table load, only between blocks
	input  logic                          i_quantWrt,
	input  mdecPkg::quantWord_t           i_quantValue,
	input  logic [3:0]                    i_quantAdr,
	input  logic                          i_quantTblSelect,

	// Block readout
	output logic                          o_outValid,
	output logic [5:0]                    o_outIdx,
	output logic [2:0]                    o_outBlock,
	output logic signed [`MDEC_OUT_W-1:0] o_outValue,
	output logic                          o_inReady
);

	// --------------------
	// Decoder to dequantizer
	// --------------------
	logic                           decWrt;
	logic signed [`MDEC_COEF_W-1:0] decData;
	logic [`MDEC_SCALE_W-1:0]       decScale;
	logic                           decIsDC;
	logic [5:0]                     decIndex;
	logic [5:0]                     decZag;
	logic                           decFull;
	logic [2:0]                     decBlock;
	logic                           decComplete;

	// Dequantizer to store
	logic                           cfWrite;
	logic [5:0]                     cfIdx;
	logic [2:0]                     cfBlock;
	logic signed [`MDEC_OUT_W-1:0]  cfValue;
	logic                           cfComplete;

	rleDecode uRleDecode (
		.i_clk            (i_clk),
		.i_arstN          (i_arstN),
		.i_rleValid       (i_rleValid),
		.i_rleData        (i_rleData),
		.i_fullBlockType  (i_fullBlockType),
		.o_dataWrt        (decWrt),
		.o_dataIn         (decData),
		.o_scale          (decScale),
		.o_isDC           (decIsDC),
		.o_index          (decIndex),
		.o_zagIndex       (decZag),
		.o_fullBlockType  (decFull),
		.o_blockNum       (decBlock),
		.o_matrixComplete (decComplete)
	);

	// Two-cycle multiply pipeline
	computeCoef uComputeCoef (
		.i_clk            (i_clk),
		.i_arstN          (i_arstN),
		.i_dataWrt        (decWrt),
		.i_dataIn         (decData),
		.i_scale          (decScale),
		.i_isDC           (decIsDC),
		.i_index          (decIndex),
		.i_zagIndex       (decZag),
		.i_fullBlockType  (decFull),
		.i_blockNum       (decBlock),
		.i_matrixComplete (decComplete),
		.i_quantWrt       (i_quantWrt),
		.i_quantValue     (i_quantValue),
		.i_quantAdr       (i_quantAdr),
		.i_quantTblSelect (i_quantTblSelect),
		.o_write          (cfWrite),
		.o_writeIdx       (cfIdx),
		.o_blockNum       (cfBlock),
		.o_coefValue      (cfValue),
		.o_matrixComplete (cfComplete)
	);

	blockStore uBlockStore (
		.i_clk            (i_clk),
		.i_arstN          (i_arstN),
		.i_write          (cfWrite),
		.i_writeIdx       (cfIdx),
		.i_blockNum       (cfBlock),
		.i_coefValue      (cfValue),
		.i_matrixComplete (cfComplete),
		.o_outValid       (o_outValid),
		.o_outIdx         (o_outIdx),
		.o_outBlock       (o_outBlock),
		.o_outValue       (o_outValue),
		.o_inReady        (o_inReady)
	);

endmodule

// ==== tests/tbMdecCore.sv ====
// Self-checking testbench for mdecCore, sends random and directed blocks against a reference model
`timescale 1ns/1ps
`include "mdec_macros.svh"

module tbMdecCore;

	localparam int     clkPeriod  = 100;
	localparam int     numBlocks  = 30;
	// 200 cycles allowed per block sent
	localparam longint watchdogNs = longint'(numBlocks) * 200 * clkPeriod;

	logic                          i_clk = 1'b0;
	logic                          i_arstN;
	logic                          i_rleValid;
	logic [15:0]                   i_rleData;
	logic                          i_fullBlockType;
	logic                          i_quantWrt;
	mdecPkg::quantWord_t           i_quantValue;
	logic [3:0]                    i_quantAdr;
	logic                          i_quantTblSelect;
	logic                          o_outValid;
	logic [5:0]                    o_outIdx;
	logic [2:0]                    o_outBlock;
	logic signed [`MDEC_OUT_W-1:0] o_outValue;
	logic                          o_inReady;

	integer                        seed;
	// Loaded tables, chroma in words 0-15, luma in 16-31
	mdecPkg::quantWord_t           quantCopy [32];
	logic [2:0]                    curBlk;
	// One entry per expected readout beat
	logic signed [`MDEC_OUT_W-1:0] expValQ [$];
	logic [2:0]                    expBlkQ [$];

	mdecCore dut (
		.i_clk            (i_clk),
		.i_arstN          (i_arstN),
		.i_rleValid       (i_rleValid),
		.i_rleData        (i_rleData),
		.i_fullBlockType  (i_fullBlockType),
		.i_quantWrt       (i_quantWrt),
		.i_quantValue     (i_quantValue),
		.i_quantAdr       (i_quantAdr),
		.i_quantTblSelect (i_quantTblSelect),
		.o_outValid       (o_outValid),
		.o_outIdx         (o_outIdx),
		.o_outBlock       (o_outBlock),
		.o_outValue       (o_outValue),
		.o_inReady        (o_inReady)
	);

	always #(clkPeriod/2) i_clk = ~i_clk;

	// --------------------
	// Error handling
	// --------------------
	task automatic stopOnError();
		$display("Done: errors found");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkValue(
		input logic signed [`MDEC_OUT_W-1:0] got,
		input logic signed [`MDEC_OUT_W-1:0] want,
		input int                            beat
	);
		if (got !== want)
		begin
			$display("[FAIL] o_outValue got %h expected %h at beat %0d", got, want, beat);
			stopOnError();
		end
	endtask

	task automatic compareIndex(input logic [5:0] got, input logic [5:0] want, input int beat);
		if (got !== want)
		begin
			$display("[FAIL] o_outIdx got %h expected %h at beat %0d", got, want, beat);
			stopOnError();
		end
	endtask

	task automatic matchBlock(input logic [2:0] got, input logic [2:0] want, input int beat);
		if (got !== want)
		begin
			$display("[FAIL] o_outBlock got %h expected %h at beat %0d", got, want, beat);
			stopOnError();
		end
	endtask

	// --------------------
	// Reference model
	// --------------------
	// Standard DC uses 8 x entry 0, standard AC scale x entry, full mode 16 x 1
	function automatic logic signed [`MDEC_OUT_W-1:0] dequantRef(
		input logic signed [`MDEC_COEF_W-1:0] level,
		input int                             zag,
		input logic [`MDEC_SCALE_W-1:0]       scale,
		input logic                           isDC,
		input logic                           fullMode,
		input logic [2:0]                     blkNum
	);
		mdecPkg::quantWord_t word;
		longint              factor;
		longint              entry;
		longint              prod;
		// Blocks above 1 read the luma table
		word = quantCopy[5'(((blkNum > 3'd1) ? 16 : 0) + zag / 4)];
		if (fullMode)
		begin
			factor = longint'(16);
			entry  = longint'(1);
		end
		else
		begin
			factor = isDC ? longint'(8) : longint'(scale);
			entry  = longint'(word.raw[5'((zag % 4) * `MDEC_QENT_W) +: `MDEC_QENT_W]);
		end
		prod = longint'(level) * factor * entry;
		// Divide by 8, keep product bits 22..3
		return prod[`MDEC_OUT_W+2:3];
	endfunction

	// --------------------
	// Stimulus
	// --------------------
	task automatic loadQuantTables();
		mdecPkg::quantWord_t word;
		int                  a;
		for (a = 0; a < 32; a++)
		begin
			// Word 15 of each table at the largest entry for the extreme block
			if (a % 16 == 15)
				word.raw = {4{7'h7F}};
			else
				word.raw = 28'($random(seed));
			quantCopy[5'(a)] = word;
			i_quantWrt       = 1'b1;
			i_quantValue     = word;
			i_quantAdr       = 4'(a % 16);
			i_quantTblSelect = (a >= 16);
			@(posedge i_clk);
			#1;
		end
		i_quantWrt = 1'b0;
	endtask

	// Kinds: 0 standard, 1 DC only, 2 overflow, 3 full matrix, 4 extreme values
	task automatic sendBlock(input int kind);
		logic [15:0]                    hw [$];
		logic signed [`MDEC_OUT_W-1:0]  blk [64];
		logic [`MDEC_SCALE_W-1:0]       scale;
		logic signed [`MDEC_COEF_W-1:0] lvl;
		logic                           fullMode;
		int                             nAc;
		int                             run;
		int                             pos;
		int                             k;
		for (k = 0; k < 64; k++)
			blk[6'(k)] = '0;
		fullMode = (kind == 3);
		scale    = (kind == 4) ? 6'd63 : 6'($random(seed));
		lvl      = (kind == 4) ? 10'h200 : 10'($random(seed));
		case (kind)
			1:       nAc = 0;
			2:       nAc = 6;
			4:       nAc = 2;
			default: nAc = {$random(seed)} % 24;
		endcase
		// DC halfword, scale on top
		hw.push_back({scale, lvl});
		blk[mdecPkg::zagToLinear(6'd0)] = dequantRef(lvl, 0, scale, 1'b1, fullMode, curBlk);
		pos = 0;
		for (k = 0; k < nAc; k++)
		begin
			if (kind == 4)
			begin
				// Zag 60 then 63, both inside the all-127 word
				run = (k == 0) ? 59 : 2;
				lvl = (k == 0) ? 10'h200 : 10'h1FF;
			end
			else
			begin
				// Six runs of 13 or more always pass 63
				run = (kind == 2) ? 12 + int'({$random(seed)} % 25) : int'({$random(seed)} % 5);
				lvl = 10'($random(seed));
			end
			pos = pos + run + 1;
			hw.push_back({6'(run), lvl});
			// Anything past 63 is dropped
			if (pos <= 63)
				blk[mdecPkg::zagToLinear(6'(pos))] =
					dequantRef(lvl, pos, scale, 1'b0, fullMode, curBlk);
		end
		hw.push_back(`MDEC_END_CODE);
		for (k = 0; k < 64; k++)
		begin
			expValQ.push_back(blk[6'(k)]);
			expBlkQ.push_back(curBlk);
		end
		curBlk = (curBlk == 3'(`MDEC_BLOCKS - 1)) ? 3'd0 : curBlk + 3'd1;

		// Start only while the store takes a new block
		while (o_inReady !== 1'b1)
		begin
			@(posedge i_clk);
			#1;
		end
		// No stall inside a block
		for (k = 0; k < hw.size(); k++)
		begin
			i_rleValid      = 1'b1;
			i_rleData       = hw[k];
			i_fullBlockType = fullMode;
			@(posedge i_clk);
			#1;
		end
		i_rleValid = 1'b0;
	endtask

	// --------------------
	// Output comparison
	// --------------------
	initial
	begin : compareOutput
		int                            beat;
		logic signed [`MDEC_OUT_W-1:0] wantVal;
		logic [2:0]                    wantBlk;
		beat = 0;
		forever
		begin
			// Outputs settled mid cycle
			@(negedge i_clk);
			if (o_outValid === 1'b1)
			begin
				if (expValQ.size() == 0)
				begin
					$display("Readout beat arrived while no block was expected");
					stopOnError();
				end
				else
				begin
					wantVal = expValQ.pop_front();
					wantBlk = expBlkQ.pop_front();
					checkValue(o_outValue, wantVal, beat);
					compareIndex(o_outIdx, 6'(beat % 64), beat);
					matchBlock(o_outBlock, wantBlk, beat);
					beat++;
				end
			end
		end
	end

	initial
	begin : watchdog
		#(watchdogNs);
		$display("Watchdog expired, block output stopped before all blocks were read out");
		stopOnError();
	end

	// --------------------
	// Main sequence
	// --------------------
	initial
	begin : mainSequence
		int i;
		int kind;
		int gap;
		seed             = 32'hab380050;
		i_arstN          = 1'b0;
		i_rleValid       = 1'b0;
		i_rleData        = '0;
		i_fullBlockType  = 1'b0;
		i_quantWrt       = 1'b0;
		i_quantValue     = '0;
		i_quantAdr       = '0;
		i_quantTblSelect = 1'b0;
		curBlk           = '0;
		repeat (4) @(posedge i_clk);
		#1;
		i_arstN = 1'b1;
		if (o_inReady !== 1'b1 || o_outValid !== 1'b0)
		begin
			$display("After reset o_inReady should be high and o_outValid low");
			stopOnError();
		end
		loadQuantTables();
		for (i = 0; i < numBlocks; i++)
		begin
			// Six standard blocks cover every block number
			if (i < 6)
				kind = 0;
			else if (i == 6)
				kind = 1;
			else if (i == 7)
				kind = 2;
			else if (i < 10)
				kind = 3;
			else if (i == 10)
				kind = 4;
			else
				kind = {$random(seed)} % 5;
			// Zero gap sends back to back
			gap = {$random(seed)} % 3;
			repeat (gap)
			begin
				@(posedge i_clk);
				#1;
			end
			sendBlock(kind);
		end
		while (expValQ.size() != 0)
			@(posedge i_clk);
		// Quiet window to catch stray beats
		repeat (70) @(posedge i_clk);
		#1;
		if (o_inReady === 1'b1)
		begin
			$display("Done: no errors");
			$finish;
		end
		else
		begin
			$display("Block store stayed busy after the last block was read out");
			stopOnError();
		end
	end

endmodule

// ==== src.f ====
+incdir+common
common/mdecPkg.sv
logic/rleDecode.sv
computeCoef/computeCoef.sv
logic/blockStore.sv
logic/mdecCore.sv
tests/tbMdecCore.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tbMdecCore
FILELIST  := src.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
LINTFLAGS := --lint-only --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Non-zero exit from the simulator fails the target
run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
